// File: la_decode_pkg.sv
/* shared decode definitions: word and one-hot field types, buffer and
   credit depths, instruction kind and alu op enums */

`default_nettype none

package la_decode_pkg;

    localparam int INST_W      = 32;
    localparam int FIFO_DEPTH  = 4;   // also upstream credits after reset
    localparam int OUT_CREDITS = 4;   // downstream credits after reset

    typedef logic [INST_W-1:0] inst_t;

    // one-hot predecode of the opcode fields
    typedef logic [63:0] op_31_26_oh_t;
    typedef logic [15:0] op_25_22_oh_t;
    typedef logic [ 3:0] op_21_20_oh_t;
    typedef logic [31:0] op_19_15_oh_t;

    typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_cnt_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0]    fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_cnt_t;

    typedef enum logic [7:0] {
        KIND_NONE,
        // 3-register alu
        KIND_ADD_W, KIND_SUB_W, KIND_SLT, KIND_SLTU, KIND_NOR,
        KIND_AND, KIND_OR, KIND_XOR, KIND_ORN, KIND_ANDN,
        // shifts
        KIND_SLL_W, KIND_SRL_W, KIND_SRA_W,
        KIND_SLLI_W, KIND_SRLI_W, KIND_SRAI_W,
        // mul / div
        KIND_MUL_W, KIND_MULH_W, KIND_MULH_WU,
        KIND_DIV_W, KIND_MOD_W, KIND_DIV_WU, KIND_MOD_WU,
        // 12-bit immediate alu
        KIND_SLTI, KIND_SLTUI, KIND_ADDI_W, KIND_ANDI, KIND_ORI, KIND_XORI,
        // memory
        KIND_LD_B, KIND_LD_H, KIND_LD_W, KIND_LD_BU, KIND_LD_HU,
        KIND_ST_B, KIND_ST_H, KIND_ST_W,
        // control flow
        KIND_JIRL, KIND_B, KIND_BL, KIND_BEQ, KIND_BNE,
        KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
        // 20-bit upper immediates
        KIND_LU12I_W, KIND_PCADDU12I
    } inst_kind_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ADD, SUB, SLT, SLTU,
        NOR, AND, OR, XOR, ORN, ANDN,
        SLL, SRL, SRA,
        MUL, MULH, MULHU,
        DIV, MOD, DIVU, MODU
    } alu_op_e;

endpackage

`default_nettype wire

// File: la_inst_fifo.sv
/* instruction word input buffer, circular with a credit pulse per pop */

`timescale 1ns/1ps
`default_nettype none

module la_inst_fifo (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       push_i,
    input  wire la_decode_pkg::inst_t push_inst_i,
    input  wire                       pop_i,
    output logic                      head_valid_o,
    output la_decode_pkg::inst_t      head_inst_o,
    output logic                      credit_o
);
    import la_decode_pkg::*;

    inst_t     mem_q [FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;
    logic      full;
    logic      do_pop;

    function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t p);
        return (p == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full         = (count_q == fifo_cnt_t'(FIFO_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_inst_o  = mem_q[rd_ptr_q];
    assign do_pop       = pop_i & head_valid_o;
    assign credit_o     = do_pop;   // slot freed, upstream may refill

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_inst_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // idle or push with pop
            endcase
        end
    end

    // upstream overran its credits
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i && full |-> do_pop)
        else $error("push into full instruction fifo");

endmodule

`default_nettype wire

// File: la_credit_counter.sv
/* downstream credit counter, gives issue permission and the pop strobe */

`timescale 1ns/1ps
`default_nettype none

module la_credit_counter (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  credit_i,
    input  wire  head_valid_i,
    output logic pop_o,
    output logic can_issue_o
);
    import la_decode_pkg::*;

    credit_cnt_t cnt_q;

    assign can_issue_o = (cnt_q != '0);
    assign pop_o       = can_issue_o & head_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= credit_cnt_t'(OUT_CREDITS);
        end else if (pop_o && !credit_i) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (credit_i && !pop_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // downstream never returns more than it was given
    a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt_q <= credit_cnt_t'(OUT_CREDITS))
        else $error("downstream credit count above limit");

endmodule

`default_nettype wire

// File: la_predecode.sv
/* opcode field predecode, four one-hot field decoders */

`timescale 1ns/1ps
`default_nettype none

module la_predecode (
    input  wire la_decode_pkg::inst_t  inst_i,
    output la_decode_pkg::op_31_26_oh_t op_31_26_oh_o,
    output la_decode_pkg::op_25_22_oh_t op_25_22_oh_o,
    output la_decode_pkg::op_21_20_oh_t op_21_20_oh_o,
    output la_decode_pkg::op_19_15_oh_t op_19_15_oh_o
);

    // major opcode
    assign op_31_26_oh_o = 64'd1 << inst_i[31:26];

    assign op_25_22_oh_o = 16'd1 << inst_i[25:22];
    assign op_21_20_oh_o = 4'd1 << inst_i[21:20];

    // minor opcode of the 3R and shift-immediate groups
    assign op_19_15_oh_o = 32'd1 << inst_i[19:15];

endmodule

`default_nettype wire

// File: la_inst_match.sv
/* instruction kind match and alu op mapping, registered output stage */

`timescale 1ns/1ps
`default_nettype none

module la_inst_match (
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire                              pop_i,
    input  wire la_decode_pkg::inst_t        inst_i,
    input  wire la_decode_pkg::op_31_26_oh_t op_31_26_oh_i,
    input  wire la_decode_pkg::op_25_22_oh_t op_25_22_oh_i,
    input  wire la_decode_pkg::op_21_20_oh_t op_21_20_oh_i,
    input  wire la_decode_pkg::op_19_15_oh_t op_19_15_oh_i,
    output logic                             out_valid_o,
    output la_decode_pkg::inst_kind_e        out_kind_o,
    output la_decode_pkg::alu_op_e           out_alu_op_o,
    output la_decode_pkg::inst_t             out_inst_o
);
    import la_decode_pkg::*;

    logic       op00;
    logic       grp_3r;    // 00/0/1 three-register
    logic       grp_md;    // 00/0/2 div and mod
    logic       grp_shi;   // 00/1/0 shift by immediate
    logic       grp_mem;   // 0a load/store
    inst_kind_e kind;
    alu_op_e    alu_op;

    assign op00    = op_31_26_oh_i[6'h00];
    assign grp_3r  = op00 & op_25_22_oh_i[4'h0] & op_21_20_oh_i[2'h1];
    assign grp_md  = op00 & op_25_22_oh_i[4'h0] & op_21_20_oh_i[2'h2];
    assign grp_shi = op00 & op_25_22_oh_i[4'h1] & op_21_20_oh_i[2'h0];
    assign grp_mem = op_31_26_oh_i[6'h0a];

    // kept encodings are disjoint, so at most one item can hit
    always_comb begin
        unique case (1'b1)
            grp_3r & op_19_15_oh_i[5'h00]:        kind = KIND_ADD_W;
            grp_3r & op_19_15_oh_i[5'h02]:        kind = KIND_SUB_W;
            grp_3r & op_19_15_oh_i[5'h04]:        kind = KIND_SLT;
            grp_3r & op_19_15_oh_i[5'h05]:        kind = KIND_SLTU;
            grp_3r & op_19_15_oh_i[5'h08]:        kind = KIND_NOR;
            grp_3r & op_19_15_oh_i[5'h09]:        kind = KIND_AND;
            grp_3r & op_19_15_oh_i[5'h0a]:        kind = KIND_OR;
            grp_3r & op_19_15_oh_i[5'h0b]:        kind = KIND_XOR;
            grp_3r & op_19_15_oh_i[5'h0c]:        kind = KIND_ORN;
            grp_3r & op_19_15_oh_i[5'h0d]:        kind = KIND_ANDN;
            grp_3r & op_19_15_oh_i[5'h0e]:        kind = KIND_SLL_W;
            grp_3r & op_19_15_oh_i[5'h0f]:        kind = KIND_SRL_W;
            grp_3r & op_19_15_oh_i[5'h10]:        kind = KIND_SRA_W;
            grp_3r & op_19_15_oh_i[5'h18]:        kind = KIND_MUL_W;
            grp_3r & op_19_15_oh_i[5'h19]:        kind = KIND_MULH_W;
            grp_3r & op_19_15_oh_i[5'h1a]:        kind = KIND_MULH_WU;
            grp_md & op_19_15_oh_i[5'h00]:        kind = KIND_DIV_W;
            grp_md & op_19_15_oh_i[5'h01]:        kind = KIND_MOD_W;
            grp_md & op_19_15_oh_i[5'h02]:        kind = KIND_DIV_WU;
            grp_md & op_19_15_oh_i[5'h03]:        kind = KIND_MOD_WU;
            grp_shi & op_19_15_oh_i[5'h01]:       kind = KIND_SLLI_W;
            grp_shi & op_19_15_oh_i[5'h09]:       kind = KIND_SRLI_W;
            grp_shi & op_19_15_oh_i[5'h11]:       kind = KIND_SRAI_W;
            op00 & op_25_22_oh_i[4'h8]:           kind = KIND_SLTI;
            op00 & op_25_22_oh_i[4'h9]:           kind = KIND_SLTUI;
            op00 & op_25_22_oh_i[4'ha]:           kind = KIND_ADDI_W;
            op00 & op_25_22_oh_i[4'hd]:           kind = KIND_ANDI;
            op00 & op_25_22_oh_i[4'he]:           kind = KIND_ORI;
            op00 & op_25_22_oh_i[4'hf]:           kind = KIND_XORI;
            grp_mem & op_25_22_oh_i[4'h0]:        kind = KIND_LD_B;
            grp_mem & op_25_22_oh_i[4'h1]:        kind = KIND_LD_H;
            grp_mem & op_25_22_oh_i[4'h2]:        kind = KIND_LD_W;
            grp_mem & op_25_22_oh_i[4'h4]:        kind = KIND_ST_B;
            grp_mem & op_25_22_oh_i[4'h5]:        kind = KIND_ST_H;
            grp_mem & op_25_22_oh_i[4'h6]:        kind = KIND_ST_W;
            grp_mem & op_25_22_oh_i[4'h8]:        kind = KIND_LD_BU;
            grp_mem & op_25_22_oh_i[4'h9]:        kind = KIND_LD_HU;
            op_31_26_oh_i[6'h13]:                 kind = KIND_JIRL;
            op_31_26_oh_i[6'h14]:                 kind = KIND_B;
            op_31_26_oh_i[6'h15]:                 kind = KIND_BL;
            op_31_26_oh_i[6'h16]:                 kind = KIND_BEQ;
            op_31_26_oh_i[6'h17]:                 kind = KIND_BNE;
            op_31_26_oh_i[6'h18]:                 kind = KIND_BLT;
            op_31_26_oh_i[6'h19]:                 kind = KIND_BGE;
            op_31_26_oh_i[6'h1a]:                 kind = KIND_BLTU;
            op_31_26_oh_i[6'h1b]:                 kind = KIND_BGEU;
            op_31_26_oh_i[6'h05] & ~inst_i[25]:   kind = KIND_LU12I_W;
            op_31_26_oh_i[6'h07] & ~inst_i[25]:   kind = KIND_PCADDU12I;
            default:                              kind = KIND_NONE;
        endcase
    end

    // address generation and pc-relative forms go through the adder
    always_comb begin
        unique case (kind)
            KIND_ADD_W, KIND_ADDI_W, KIND_PCADDU12I,
            KIND_LD_B, KIND_LD_H, KIND_LD_W, KIND_LD_BU, KIND_LD_HU,
            KIND_ST_B, KIND_ST_H, KIND_ST_W:      alu_op = ADD;
            KIND_SUB_W:                           alu_op = SUB;
            KIND_SLT, KIND_SLTI:                  alu_op = SLT;
            KIND_SLTU, KIND_SLTUI:                alu_op = SLTU;
            KIND_NOR:                             alu_op = NOR;
            KIND_AND, KIND_ANDI:                  alu_op = AND;
            KIND_OR, KIND_ORI:                    alu_op = OR;
            KIND_XOR, KIND_XORI:                  alu_op = XOR;
            KIND_ORN:                             alu_op = ORN;
            KIND_ANDN:                            alu_op = ANDN;
            KIND_SLL_W, KIND_SLLI_W:              alu_op = SLL;
            KIND_SRL_W, KIND_SRLI_W:              alu_op = SRL;
            KIND_SRA_W, KIND_SRAI_W:              alu_op = SRA;
            KIND_MUL_W:                           alu_op = MUL;
            KIND_MULH_W:                          alu_op = MULH;
            KIND_MULH_WU:                         alu_op = MULHU;
            KIND_DIV_W:                           alu_op = DIV;
            KIND_MOD_W:                           alu_op = MOD;
            KIND_DIV_WU:                          alu_op = DIVU;
            KIND_MOD_WU:                          alu_op = MODU;
            default:                              alu_op = ALU_NONE;   // branches, lu12i.w
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= pop_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            out_kind_o   <= kind;
            out_alu_op_o <= alu_op;
            out_inst_o   <= inst_i;   // immediates extracted downstream
        end
    end

endmodule

`default_nettype wire

// File: la_decode_stage.sv
/* decode stage top, input fifo, credit counter, predecode and match */

`timescale 1ns/1ps
`default_nettype none

module la_decode_stage (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       in_valid_i,
    input  wire la_decode_pkg::inst_t in_inst_i,
    output logic                      credit_o,
    input  wire                       credit_i,
    output logic                      out_valid_o,
    output la_decode_pkg::inst_kind_e out_kind_o,
    output la_decode_pkg::alu_op_e    out_alu_op_o,
    output la_decode_pkg::inst_t      out_inst_o
);
    import la_decode_pkg::*;

    logic         head_valid;
    inst_t        head_inst;
    logic         pop;
    op_31_26_oh_t op_31_26_oh;
    op_25_22_oh_t op_25_22_oh;
    op_21_20_oh_t op_21_20_oh;
    op_19_15_oh_t op_19_15_oh;

    la_inst_fifo u_la_inst_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (in_valid_i),
        .push_inst_i  (in_inst_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .credit_o     (credit_o)
    );

    la_credit_counter u_la_credit_counter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .credit_i     (credit_i),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .can_issue_o  ()   // pop already carries it
    );

    la_predecode u_la_predecode (
        .inst_i        (head_inst),
        .op_31_26_oh_o (op_31_26_oh),
        .op_25_22_oh_o (op_25_22_oh),
        .op_21_20_oh_o (op_21_20_oh),
        .op_19_15_oh_o (op_19_15_oh)
    );

    la_inst_match u_la_inst_match (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pop_i         (pop),
        .inst_i        (head_inst),
        .op_31_26_oh_i (op_31_26_oh),
        .op_25_22_oh_i (op_25_22_oh),
        .op_21_20_oh_i (op_21_20_oh),
        .op_19_15_oh_i (op_19_15_oh),
        .out_valid_o   (out_valid_o),
        .out_kind_o    (out_kind_o),
        .out_alu_op_o  (out_alu_op_o),
        .out_inst_o    (out_inst_o)
    );

endmodule

`default_nettype wire

// File: tb_la_decode_ref.svh
/* reference decode rules and xorshift generator for the decode stage testbench */

`ifndef TB_LA_DECODE_REF_SVH
`define TB_LA_DECODE_REF_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// expected kind straight from the encoding fields
function automatic inst_kind_e ref_kind(input logic [31:0] w);
    inst_kind_e k;
    logic [5:0] f6;
    logic [3:0] f4;
    logic [1:0] f2;
    logic [4:0] f5;
    f6 = w[31:26];
    f4 = w[25:22];
    f2 = w[21:20];
    f5 = w[19:15];
    k = KIND_NONE;
    if (f6 == 6'h00 && f4 == 4'h0 && f2 == 2'h1) begin
        case (f5)
            5'h00: k = KIND_ADD_W;   5'h02: k = KIND_SUB_W;
            5'h04: k = KIND_SLT;     5'h05: k = KIND_SLTU;
            5'h08: k = KIND_NOR;     5'h09: k = KIND_AND;
            5'h0a: k = KIND_OR;      5'h0b: k = KIND_XOR;
            5'h0c: k = KIND_ORN;     5'h0d: k = KIND_ANDN;
            5'h0e: k = KIND_SLL_W;   5'h0f: k = KIND_SRL_W;
            5'h10: k = KIND_SRA_W;   5'h18: k = KIND_MUL_W;
            5'h19: k = KIND_MULH_W;  5'h1a: k = KIND_MULH_WU;
            default: k = KIND_NONE;
        endcase
    end else if (f6 == 6'h00 && f4 == 4'h0 && f2 == 2'h2) begin
        case (f5)
            5'h00: k = KIND_DIV_W;   5'h01: k = KIND_MOD_W;
            5'h02: k = KIND_DIV_WU;  5'h03: k = KIND_MOD_WU;
            default: k = KIND_NONE;
        endcase
    end else if (f6 == 6'h00 && f4 == 4'h1 && f2 == 2'h0) begin
        if (f5 == 5'h01) k = KIND_SLLI_W;
        if (f5 == 5'h09) k = KIND_SRLI_W;
        if (f5 == 5'h11) k = KIND_SRAI_W;
    end else if (f6 == 6'h00) begin
        case (f4)
            4'h8: k = KIND_SLTI;     4'h9: k = KIND_SLTUI;
            4'ha: k = KIND_ADDI_W;   4'hd: k = KIND_ANDI;
            4'he: k = KIND_ORI;      4'hf: k = KIND_XORI;
            default: k = KIND_NONE;
        endcase
    end else if (f6 == 6'h0a) begin
        case (f4)
            4'h0: k = KIND_LD_B;     4'h1: k = KIND_LD_H;
            4'h2: k = KIND_LD_W;     4'h4: k = KIND_ST_B;
            4'h5: k = KIND_ST_H;     4'h6: k = KIND_ST_W;
            4'h8: k = KIND_LD_BU;    4'h9: k = KIND_LD_HU;
            default: k = KIND_NONE;
        endcase
    end else if (f6 >= 6'h13 && f6 <= 6'h1b) begin
        k = inst_kind_e'(int'(KIND_JIRL) + int'(f6 - 6'h13));   // enum order follows opcode
    end else if (f6 == 6'h05 && !w[25]) begin
        k = KIND_LU12I_W;
    end else if (f6 == 6'h07 && !w[25]) begin
        k = KIND_PCADDU12I;
    end
    return k;
endfunction

function automatic alu_op_e ref_alu(input inst_kind_e k);
    case (k)
        KIND_ADD_W, KIND_ADDI_W, KIND_PCADDU12I, KIND_LD_B, KIND_LD_H, KIND_LD_W,
        KIND_LD_BU, KIND_LD_HU, KIND_ST_B, KIND_ST_H, KIND_ST_W: return ADD;
        KIND_SUB_W: return SUB;
        KIND_SLT, KIND_SLTI: return SLT;
        KIND_SLTU, KIND_SLTUI: return SLTU;
        KIND_NOR: return NOR;
        KIND_AND, KIND_ANDI: return AND;
        KIND_OR, KIND_ORI: return OR;
        KIND_XOR, KIND_XORI: return XOR;
        KIND_ORN: return ORN;
        KIND_ANDN: return ANDN;
        KIND_SLL_W, KIND_SLLI_W: return SLL;
        KIND_SRL_W, KIND_SRLI_W: return SRL;
        KIND_SRA_W, KIND_SRAI_W: return SRA;
        KIND_MUL_W: return MUL;
        KIND_MULH_W: return MULH;
        KIND_MULH_WU: return MULHU;
        KIND_DIV_W: return DIV;
        KIND_MOD_W: return MOD;
        KIND_DIV_WU: return DIVU;
        KIND_MOD_WU: return MODU;
        default: return ALU_NONE;
    endcase
endfunction

`endif

// File: tb_la_decode_stage.sv
/* decode stage testbench: upstream and downstream credit models,
   in-order compare against the reference rules, timeout */

`timescale 1ns/1ps
`default_nettype none

module tb_la_decode_stage;
    import la_decode_pkg::*;
    `include "tb_la_decode_ref.svh"

    localparam int TOTAL_WORDS = 112;
    localparam int MAX_CYCLES  = TOTAL_WORDS * 20 + 200;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic in_valid_i;
    logic credit_i;
    logic credit_o;
    logic out_valid_o;
    inst_t in_inst_i;
    inst_t out_inst_o;
    inst_kind_e out_kind_o;
    alu_op_e out_alu_op_o;

    logic [31:0] seed = 32'hfede;
    logic [31:0] seed_dn = 32'hfede;
    inst_t exp_q[$];
    time t_q[$];
    int n_sent = 0;
    int n_cred = 0;
    int n_out = 0;
    int n_ret = 0;
    int n_checks = 0;
    int n_err = 0;
    int cycles = 0;
    bit hold = 1'b0;
    bit slow = 1'b0;

    la_decode_stage u_la_decode_stage (.*);

    always #50 clk_i = ~clk_i;

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // caller sits on a falling edge
    task automatic send_word(input logic [31:0] pat, input int nfix);
        inst_t w;
        seed = xorshift(seed);
        w = pat | (seed & (32'hffff_ffff >> nfix));
        while (FIFO_DEPTH + n_cred - n_sent <= 0) @(negedge clk_i);
        in_valid_i = 1'b1;
        in_inst_i = w;
        n_sent++;
        exp_q.push_back(w);
        t_q.push_back($time);
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || n_ret != n_out) @(negedge clk_i);
    endtask

    task automatic report(input string name, input int err0);
        $display("%s: done, %0d errors", name, n_err - err0);
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i && credit_o) begin
            n_cred++;
        end
    end

    // compare process
    always @(posedge clk_i) begin
        inst_t w;
        time t;
        if (rst_n_i && out_valid_o) begin
            n_out++;
            if (exp_q.size() == 0) begin
                n_err++;
                $display("output appeared at %0t with no word outstanding", $time);
            end else begin
                w = exp_q.pop_front();
                t = t_q.pop_front();
                check_eq(out_kind_o, ref_kind(w), "kind");
                check_eq(out_alu_op_o, ref_alu(ref_kind(w)), "alu op");
                check_eq(out_inst_o, w, "passed word");
                if ($time - t < 200) begin
                    n_err++;
                    $display("ERR %0t: latency below 2 cycles", $time);
                end
            end
        end
    end

    // downstream credit return
    always @(negedge clk_i) begin
        credit_i = 1'b0;
        if (rst_n_i && !hold && n_out > n_ret) begin
            seed_dn = xorshift(seed_dn);
            if (!slow || seed_dn[1:0] == 2'b00) begin
                credit_i = 1'b1;
                n_ret++;
            end
        end
    end

    initial begin
        logic [4:0] f5_3r[16];
        logic [3:0] f4_imm[6];
        logic [3:0] f4_mem[8];
        logic [31:0] dropped[8];
        int e0;
        int c0;
        int o0;
        rst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_inst_i = '0;
        credit_i = 1'b0;
        f5_3r = '{0, 2, 4, 5, 8, 9, 10, 11, 12, 13, 14, 15, 16, 24, 25, 26};
        f4_imm = '{8, 9, 10, 13, 14, 15};
        f4_mem = '{0, 1, 2, 4, 5, 6, 8, 9};
        dropped = '{32'h0400_0000, 32'h0648_2800, 32'h002b_0000,
                    32'h002a_0000, 32'h1800_0000, 32'h3872_0000,
                    32'h3872_8000, 32'h2000_0000};
        e0 = n_err;
        repeat (16) begin
            @(negedge clk_i);
            check_eq(out_valid_o, 1'b0, "out_valid in reset");
            check_eq(credit_o, 1'b0, "credit_o in reset");
        end
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_eq({out_valid_o, credit_o}, 2'b00, "idle after reset");
        end
        check_eq(FIFO_DEPTH + n_cred - n_sent, FIFO_DEPTH, "upstream credits after reset");
        report("reset state", e0);
        @(negedge clk_i);

        e0 = n_err;
        slow = 1'b1;
        foreach (f5_3r[i]) send_word({6'h00, 4'h0, 2'h1, f5_3r[i], 15'b0}, 17);
        for (int i = 0; i < 4; i++) send_word({6'h00, 4'h0, 2'h2, 5'(i), 15'b0}, 17);
        send_word({6'h00, 4'h1, 2'h0, 5'h01, 15'b0}, 17);
        send_word({6'h00, 4'h1, 2'h0, 5'h09, 15'b0}, 17);
        send_word({6'h00, 4'h1, 2'h0, 5'h11, 15'b0}, 17);
        foreach (f4_imm[i]) send_word({6'h00, f4_imm[i], 22'b0}, 10);
        foreach (f4_mem[i]) send_word({6'h0a, f4_mem[i], 22'b0}, 10);
        for (int i = 'h13; i <= 'h1b; i++) send_word({6'(i), 26'b0}, 6);
        send_word({6'h05, 26'b0}, 7);
        send_word({6'h07, 26'b0}, 7);
        wait_drain();
        report("kept encodings", e0);

        e0 = n_err;
        foreach (dropped[i]) send_word(dropped[i], 32);
        repeat (16) send_word(32'h0, 0);
        wait_drain();
        report("dropped and random words", e0);

        e0 = n_err;
        slow = 1'b0;
        repeat (32) send_word(32'h0, 0);
        wait_drain();
        report("full rate", e0);

        e0 = n_err;
        hold = 1'b1;
        o0 = n_out;
        repeat (8) send_word(32'h0, 0);
        repeat (10) @(negedge clk_i);
        c0 = n_cred;
        repeat (10) @(negedge clk_i);
        check_eq(n_out - o0, OUT_CREDITS, "outputs while credits withheld");
        check_eq(n_cred, c0, "credit_o pulses with fifo full");
        hold = 1'b0;
        wait_drain();
        report("back-pressure", e0);

        $display("%0d checks, %0d errors", n_checks, n_err);
        if (n_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
la_decode_pkg.sv
la_inst_fifo.sv
la_credit_counter.sv
la_predecode.sv
la_inst_match.sv
la_decode_stage.sv
tb_la_decode_stage.sv

// File: Bender.yml
package:
  name: la_decode_stage

sources:
  - include_dirs:
      - .
    files:
      - la_decode_pkg.sv
      - la_inst_fifo.sv
      - la_credit_counter.sv
      - la_predecode.sv
      - la_inst_match.sv
      - la_decode_stage.sv
      - tb_la_decode_stage.sv
